/* src/core_pkg.sv */
package core_pkg;

    // array geometry
    localparam int num_cores = 4;
    localparam int core_bits = 2;

    // log2 of words per core memory
    localparam int insn_depth = 6; // 64 instruction words
    localparam int data_depth = 7; // 128 data words

    // The loader always fills the whole instruction memory first,
    // so data_depth must not be smaller than insn_depth.

    // memory word types
    typedef logic [31:0] insn_word_t;
    typedef logic [31:0] data_word_t;

endpackage

/* src/bus_pkg.sv */
package bus_pkg;

    // one bus line holds sixteen 32-bit words
    localparam int line_bits = 512;
    localparam int words_per_line = 16;

    // byte offset within a line
    localparam int line_offset_bits = 6;

    // byte address width of the bus
    localparam int addr_bits = 64;

endpackage

/* src/core_ram.sv */
`timescale 1ns/10ps

module core_ram #(
    parameter type word_t = logic [31:0],
    parameter int depth = 6
) (
    input  logic             clk,
    input  logic             we,
    input  logic [depth-1:0] wr_addr,
    input  word_t            wr_word,
    input  logic [depth-1:0] rd_addr,
    output word_t            rd_word
);

    word_t mem [2**depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_word <= mem[rd_addr];
    end

endmodule

/* src/core_mem_bank.sv */
`timescale 1ns/10ps

module core_mem_bank (
    input  logic                            clk,
    input  logic                            insn_we,
    input  logic                            data_we,
    input  logic [core_pkg::core_bits-1:0]  wr_core,
    input  logic [core_pkg::data_depth-1:0] wr_addr,
    input  logic [31:0]                     wr_word,
    input  logic [core_pkg::core_bits-1:0]  rd_core,
    input  logic                            rd_insn,
    input  logic [core_pkg::data_depth-1:0] rd_addr,
    output logic [31:0]                     rd_word
);

    core_pkg::insn_word_t insn_rd [core_pkg::num_cores];
    core_pkg::data_word_t data_rd [core_pkg::num_cores];

    logic [core_pkg::core_bits-1:0] rd_core_q;
    logic                           rd_insn_q;

    for (genvar c = 0; c < core_pkg::num_cores; c++) begin : gen_core
        logic core_sel;

        assign core_sel = (wr_core == c);

        core_ram #(
            .word_t (core_pkg::insn_word_t),
            .depth  (core_pkg::insn_depth)
        ) i_insn_ram (
            .clk     (clk),
            .we      (insn_we && core_sel),
            .wr_addr (wr_addr[core_pkg::insn_depth-1:0]),
            .wr_word (wr_word),
            .rd_addr (rd_addr[core_pkg::insn_depth-1:0]),
            .rd_word (insn_rd[c])
        );

        core_ram #(
            .word_t (core_pkg::data_word_t),
            .depth  (core_pkg::data_depth)
        ) i_data_ram (
            .clk     (clk),
            .we      (data_we && core_sel),
            .wr_addr (wr_addr),
            .wr_word (wr_word),
            .rd_addr (rd_addr),
            .rd_word (data_rd[c])
        );
    end

    // select follows the ram read by one cycle
    always_ff @(posedge clk) begin
        rd_core_q <= rd_core;
        rd_insn_q <= rd_insn;
    end

    assign rd_word = rd_insn_q ? insn_rd[rd_core_q] : data_rd[rd_core_q];

endmodule

/* src/data_loader.sv */
`timescale 1ns/10ps

module data_loader (
    input  logic                                 clk,
    input  logic                                 reset,

    input  logic                                 kick,
    input  logic [bus_pkg::addr_bits-1:0]        base_addr,
    input  logic [core_pkg::core_bits-1:0]       target_core,
    output logic                                 busy,

    input  logic                                 m0_waitrequest,
    input  logic [bus_pkg::line_bits-1:0]        m0_readdata,
    input  logic                                 m0_readdatavalid,
    output logic [bus_pkg::addr_bits-1:0]        m0_address,
    output logic                                 m0_read,
    output logic [bus_pkg::line_bits/8-1:0]      m0_byteenable,

    output logic                                 insn_we,
    output logic                                 data_we,
    output logic [core_pkg::core_bits-1:0]       wr_core,
    output logic [core_pkg::data_depth-1:0]      wr_addr,
    output logic [31:0]                          wr_word
);

    typedef enum logic [2:0] {
        st_idle,
        st_req,
        st_wait,
        st_insn,
        st_data
    } state_t;

    state_t state;

    logic [bus_pkg::addr_bits-1:0]                          base_q;
    logic [core_pkg::core_bits-1:0]                         core_q;
    logic [bus_pkg::addr_bits-bus_pkg::line_offset_bits-1:0] line_cnt;
    logic [core_pkg::insn_depth-1:0]                        insn_cnt;
    logic [core_pkg::data_depth-1:0]                        data_cnt;
    logic                                                   insn_done;
    logic [bus_pkg::line_bits-1:0]                          line_q;

    logic insn_last_slot;
    logic data_last_slot;

    // low counter bits index the word slot in the current line
    assign insn_last_slot = (insn_cnt[$clog2(bus_pkg::words_per_line)-1:0] == '1);
    assign data_last_slot = (data_cnt[$clog2(bus_pkg::words_per_line)-1:0] == '1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            line_cnt  <= '0;
            insn_cnt  <= '0;
            data_cnt  <= '0;
            insn_done <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (kick) begin
                        state     <= st_req;
                        line_cnt  <= '0;
                        insn_cnt  <= '0;
                        data_cnt  <= '0;
                        insn_done <= 1'b0;
                    end
                end

                st_req: begin
                    if (!m0_waitrequest) begin // request accepted
                        state <= st_wait;
                    end
                end

                st_wait: begin
                    if (m0_readdatavalid) begin
                        state <= insn_done ? st_data : st_insn;
                    end
                end

                st_insn: begin
                    insn_cnt <= insn_cnt + 1'b1;
                    if (insn_last_slot) begin
                        line_cnt <= line_cnt + 1'b1;
                        state    <= st_req;
                        if (insn_cnt == '1) begin
                            insn_done <= 1'b1; // data lines follow
                        end
                    end
                end

                st_data: begin
                    data_cnt <= data_cnt + 1'b1;
                    if (data_last_slot) begin
                        line_cnt <= line_cnt + 1'b1;
                        state    <= (data_cnt == '1) ? st_idle : st_req;
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && kick) begin
            base_q <= base_addr;
            core_q <= target_core;
        end
        if (state == st_wait && m0_readdatavalid) begin
            line_q <= m0_readdata;
        end else if (state == st_insn || state == st_data) begin
            line_q <= {line_q[bus_pkg::line_bits-33:0], 32'h0}; // next slot to the top
        end
    end

    assign busy = (state != st_idle) || kick;

    // address held steady while waitrequest stalls
    assign m0_address    = base_q + {line_cnt, {bus_pkg::line_offset_bits{1'b0}}};
    assign m0_read       = (state == st_req);
    assign m0_byteenable = {(bus_pkg::line_bits/8){m0_read}};

    assign insn_we = (state == st_insn);
    assign data_we = (state == st_data);
    assign wr_core = core_q;
    assign wr_addr = insn_we
                   ? {{(core_pkg::data_depth-core_pkg::insn_depth){1'b0}}, insn_cnt}
                   : data_cnt;
    assign wr_word = line_q[bus_pkg::line_bits-1 -: 32]; // slot 0 is the top word

endmodule

/* src/loader_top.sv */
`timescale 1ns/10ps

module loader_top (
    input  logic                            clk,
    input  logic                            reset,

    input  logic                            kick,
    input  logic [bus_pkg::addr_bits-1:0]   base_addr,
    input  logic [core_pkg::core_bits-1:0]  target_core,
    output logic                            busy,

    input  logic                            m0_waitrequest,
    input  logic [bus_pkg::line_bits-1:0]   m0_readdata,
    input  logic                            m0_readdatavalid,
    output logic [bus_pkg::addr_bits-1:0]   m0_address,
    output logic                            m0_read,
    output logic [bus_pkg::line_bits/8-1:0] m0_byteenable,

    input  logic [core_pkg::core_bits-1:0]  rd_core,
    input  logic                            rd_insn,
    input  logic [core_pkg::data_depth-1:0] rd_addr,
    output logic [31:0]                     rd_word
);

    logic                            insn_we;
    logic                            data_we;
    logic [core_pkg::core_bits-1:0]  wr_core;
    logic [core_pkg::data_depth-1:0] wr_addr;
    logic [31:0]                     wr_word;

    data_loader i_data_loader (
        .clk              (clk),
        .reset            (reset),
        .kick             (kick),
        .base_addr        (base_addr),
        .target_core      (target_core),
        .busy             (busy),
        .m0_waitrequest   (m0_waitrequest),
        .m0_readdata      (m0_readdata),
        .m0_readdatavalid (m0_readdatavalid),
        .m0_address       (m0_address),
        .m0_read          (m0_read),
        .m0_byteenable    (m0_byteenable),
        .insn_we          (insn_we),
        .data_we          (data_we),
        .wr_core          (wr_core),
        .wr_addr          (wr_addr),
        .wr_word          (wr_word)
    );

    core_mem_bank i_core_mem_bank (
        .clk     (clk),
        .insn_we (insn_we),
        .data_we (data_we),
        .wr_core (wr_core),
        .wr_addr (wr_addr),
        .wr_word (wr_word),
        .rd_core (rd_core),
        .rd_insn (rd_insn),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

endmodule

/* dv/loader_props.sv */
`timescale 1ns/10ps

module loader_props (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 busy,
    input logic                                 m0_read,
    input logic                                 m0_waitrequest,
    input logic [bus_pkg::addr_bits-1:0]        m0_address,
    input logic                                 insn_we,
    input logic                                 data_we
);

    // a stalled request stays on the bus unchanged
    a_req_held: assert property (@(posedge clk) disable iff (reset)
        m0_read && m0_waitrequest |=> m0_read && $stable(m0_address))
        else $error("read request dropped or address moved under waitrequest");

    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(insn_we && data_we))
        else $error("instruction and data write strobes high together");

    a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
        !busy |-> !m0_read)
        else $error("read issued while idle");

    a_busy_write: assert property (@(posedge clk) disable iff (reset)
        (insn_we || data_we) |-> busy)
        else $error("memory write while not busy");

endmodule

bind data_loader loader_props i_loader_props (
    .clk            (clk),
    .reset          (reset),
    .busy           (busy),
    .m0_read        (m0_read),
    .m0_waitrequest (m0_waitrequest),
    .m0_address     (m0_address),
    .insn_we        (insn_we),
    .data_we        (data_we)
);

/* dv/avalon_mem_model.sv */
`timescale 1ns/10ps

module avalon_mem_model (
    input  logic                            clk,
    input  logic                            reset,

    input  logic                            stall_en,
    input  logic                            delay_en,
    input  logic [31:0]                     rnd,
    input  logic [bus_pkg::line_bits-1:0]   line_data,
    output logic [bus_pkg::addr_bits-1:0]   line_addr,

    input  logic [bus_pkg::addr_bits-1:0]   m0_address,
    input  logic                            m0_read,
    output logic                            m0_waitrequest,
    output logic [bus_pkg::line_bits-1:0]   m0_readdata,
    output logic                            m0_readdatavalid
);

    logic       pending;
    logic [4:0] delay;

    always @(posedge clk) begin
        if (reset) begin
            m0_waitrequest   <= 1'b0;
            m0_readdatavalid <= 1'b0;
            m0_readdata      <= '0;
            line_addr        <= '0;
            pending          <= 1'b0;
            delay            <= '0;
        end else begin
            m0_waitrequest   <= stall_en && rnd[31]; // about half the cycles stall
            m0_readdatavalid <= 1'b0;

            if (pending) begin
                if (delay == '0) begin
                    m0_readdatavalid <= 1'b1;
                    m0_readdata      <= line_data;
                    pending          <= 1'b0;
                end else begin
                    delay <= delay - 1'b1;
                end
            end

            // accepted read
            if (m0_read && !m0_waitrequest) begin
                pending   <= 1'b1;
                line_addr <= m0_address;
                delay     <= delay_en ? rnd[20:16] % 5'd6 : 5'd0; // 0 to 5 extra cycles
            end
        end
    end

endmodule

/* dv/tb_loader.sv */
`timescale 1ns/10ps

module tb_loader;

    localparam int timeout_cycles = 2000;
    localparam int insn_words = 2 ** core_pkg::insn_depth;
    localparam int data_words = 2 ** core_pkg::data_depth;

    localparam logic [63:0] base0 = 64'h0000_0001_2345_6000;
    localparam logic [63:0] base1 = 64'h0000_0000_8000_0000;
    localparam logic [63:0] base2 = 64'hffff_ffff_ffff_f000;
    localparam logic [63:0] base3 = 64'h0000_0040_0000_0fc0; // crosses a 4k page
    localparam logic [63:0] base4 = 64'h1234_5678_0000_0100;
    localparam logic [63:0] base5 = 64'h0bad_0000_0000_0000;

    logic                            clk;
    logic                            reset;
    logic                            kick;
    logic [bus_pkg::addr_bits-1:0]   base_addr;
    logic [core_pkg::core_bits-1:0]  target_core;
    logic                            busy;
    logic                            m0_waitrequest;
    logic [bus_pkg::line_bits-1:0]   m0_readdata;
    logic                            m0_readdatavalid;
    logic [bus_pkg::addr_bits-1:0]   m0_address;
    logic                            m0_read;
    logic [bus_pkg::line_bits/8-1:0] m0_byteenable;
    logic [core_pkg::core_bits-1:0]  rd_core;
    logic                            rd_insn;
    logic [core_pkg::data_depth-1:0] rd_addr;
    logic [31:0]                     rd_word;

    logic                            stall_en;
    logic                            delay_en;
    logic [31:0]                     rnd_state;
    logic [bus_pkg::addr_bits-1:0]   line_addr;
    logic [bus_pkg::line_bits-1:0]   line_data;

    loader_top i_loader_top (
        .clk              (clk),
        .reset            (reset),
        .kick             (kick),
        .base_addr        (base_addr),
        .target_core      (target_core),
        .busy             (busy),
        .m0_waitrequest   (m0_waitrequest),
        .m0_readdata      (m0_readdata),
        .m0_readdatavalid (m0_readdatavalid),
        .m0_address       (m0_address),
        .m0_read          (m0_read),
        .m0_byteenable    (m0_byteenable),
        .rd_core          (rd_core),
        .rd_insn          (rd_insn),
        .rd_addr          (rd_addr),
        .rd_word          (rd_word)
    );

    avalon_mem_model i_avalon_mem_model (
        .clk              (clk),
        .reset            (reset),
        .stall_en         (stall_en),
        .delay_en         (delay_en),
        .rnd              (rnd_state),
        .line_data        (line_data),
        .line_addr        (line_addr),
        .m0_address       (m0_address),
        .m0_read          (m0_read),
        .m0_waitrequest   (m0_waitrequest),
        .m0_readdata      (m0_readdata),
        .m0_readdatavalid (m0_readdatavalid)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk) begin
        rnd_state <= lcg_next(rnd_state);
    end

    // fixed hash of line address and word slot
    function automatic logic [31:0] expected_word(input logic [63:0] addr, input int slot);
        logic [31:0] h;
        h = addr[31:0] ^ addr[63:32] ^ 32'h9e37_79b9;
        h = h * 32'h0101_0193 + slot * 32'h0005_f00d;
        h = h ^ (h >> 15);
        return h;
    endfunction

    function automatic logic [bus_pkg::line_bits-1:0] make_line(input logic [63:0] addr);
        logic [bus_pkg::line_bits-1:0] line_val;
        for (int s = 0; s < bus_pkg::words_per_line; s++) begin
            line_val[bus_pkg::line_bits-1-32*s -: 32] = expected_word(addr, s); // slot 0 on top
        end
        return line_val;
    endfunction

    assign line_data = make_line(line_addr);

    // word expected in a core memory after a load from base
    function automatic logic [31:0] expected_mem(input logic [63:0] base, input logic is_insn,
                                                 input int idx);
        int line_idx;
        int slot;
        line_idx = idx / bus_pkg::words_per_line;
        slot = idx % bus_pkg::words_per_line;
        if (!is_insn) begin
            line_idx = line_idx + insn_words / bus_pkg::words_per_line;
        end
        return expected_word(base + (64'(line_idx) << bus_pkg::line_offset_bits), slot);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // every read asks for the whole line
    always @(negedge clk) begin
        if (!reset && m0_read) begin
            check("m0_byteenable[63:32]", m0_byteenable[63:32], 32'hffff_ffff);
            check("m0_byteenable[31:0]", m0_byteenable[31:0], 32'hffff_ffff);
        end
    end

    task automatic wait_idle(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy) begin
            if (cycles == timeout_cycles) begin
                $display("busy still high after %0d cycles during %s", timeout_cycles, what);
                $display("Test FAILED");
                $fatal(1, "timeout");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic start_load(input logic [core_pkg::core_bits-1:0] core,
                              input logic [63:0] base);
        @(posedge clk);
        kick        <= 1'b1;
        base_addr   <= base;
        target_core <= core;
        @(negedge clk);
        check("busy", {31'b0, busy}, 32'h1); // high in the kick cycle
        check("m0_read", {31'b0, m0_read}, 32'h0);
        @(posedge clk);
        kick <= 1'b0;
        @(negedge clk);
        check("m0_read", {31'b0, m0_read}, 32'h1);
    endtask

    task automatic read_word(input logic [core_pkg::core_bits-1:0] core, input logic is_insn,
                             input int idx, output logic [31:0] word);
        @(posedge clk);
        rd_core <= core;
        rd_insn <= is_insn;
        rd_addr <= idx[core_pkg::data_depth-1:0];
        @(posedge clk);
        @(negedge clk);
        word = rd_word;
    endtask

    task automatic readback_core(input logic [core_pkg::core_bits-1:0] core,
                                 input logic [63:0] base);
        logic [31:0] got;
        logic        is_insn;
        int          idx;
        for (int i = 0; i < insn_words + data_words; i++) begin
            is_insn = (i < insn_words);
            idx = is_insn ? i : i - insn_words;
            read_word(core, is_insn, idx, got);
            check($sformatf("rd_word core %0d %s[%0d]", core, is_insn ? "insn" : "data", idx),
                  got, expected_mem(base, is_insn, idx));
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        kick        = 1'b0;
        base_addr   = '0;
        target_core = '0;
        rd_core     = '0;
        rd_insn     = 1'b0;
        rd_addr     = '0;
        stall_en    = 1'b0;
        delay_en    = 1'b0;
        rnd_state   = 32'd83;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("busy", {31'b0, busy}, 32'h0);
        check("m0_read", {31'b0, m0_read}, 32'h0);

        start_load(2'd0, base0);
        wait_idle("load into core 0");
        readback_core(2'd0, base0);

        start_load(2'd2, base1);
        wait_idle("load into core 2");
        readback_core(2'd2, base1);
        readback_core(2'd0, base0); // core 0 untouched

        stall_en = 1'b1;
        start_load(2'd3, base2);
        wait_idle("load with waitrequest stalls");
        readback_core(2'd3, base2);

        stall_en = 1'b0;
        delay_en = 1'b1;
        start_load(2'd1, base3);
        wait_idle("load with readdatavalid delays");
        readback_core(2'd1, base3);

        // second kick lands in the middle of a load
        stall_en = 1'b1;
        start_load(2'd1, base4);
        repeat (3) @(posedge clk);
        @(negedge clk);
        check("busy", {31'b0, busy}, 32'h1);
        @(posedge clk);
        kick        <= 1'b1;
        base_addr   <= base5;
        target_core <= 2'd0;
        @(posedge clk);
        kick <= 1'b0;
        wait_idle("load with ignored second kick");
        readback_core(2'd1, base4);
        readback_core(2'd0, base0);

        $display("Test OK");
        $finish;
    end

endmodule

/* build.f */
src/core_pkg.sv
src/bus_pkg.sv
src/core_ram.sv
src/core_mem_bank.sv
src/data_loader.sv
src/loader_top.sv
dv/loader_props.sv
dv/avalon_mem_model.sv
dv/tb_loader.sv

/* run.sh */
#!/bin/sh
# build the loader testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    -Wno-fatal \
    --top-module tb_loader \
    --Mdir obj_dir \
    -o tb_loader_sim \
    -f build.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_loader_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$log"; then
    echo "failure reported in $log"
    exit 1
fi

echo "simulation passed"
exit 0
